//--- filelist.f
lenet_pkg.sv
weight_ram.sv
param_arbiter.sv
param_stream_loader.sv
fc_layer_engine.sv
max_label_picker.sv
lenet_classifier_top.sv
lenet_classifier_props.sv
lenet_classifier_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= lenet_classifier_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- lenet_classifier_tb.sv
`timescale 1ns/1ns

module lenet_classifier_tb
	import lenet_pkg::*;
();

	localparam int HALF_PERIOD = 5;
	localparam int WAIT_LIMIT  = 4000;

	logic               i_sclk;
	logic               i_rstn;
	logic               i_in_valid;
	logic [7:0]         i_in_data;
	logic               o_in_ready;
	logic [LABEL_W-1:0] o_label;
	logic               o_label_valid;

	logic [31:0]        lcg_state;
	int                 model_w [N_OUT][N_IN];
	int                 model_b [N_OUT];
	logic [LABEL_W-1:0] label_q [$];
	int                 tests;
	int                 checks;
	int                 errors;
	bit                 run_over;

	lenet_classifier_top lenet_classifier_top_i (
		.i_sclk        (i_sclk),
		.i_rstn        (i_rstn),
		.i_in_valid    (i_in_valid),
		.o_in_ready    (o_in_ready),
		.i_in_data     (i_in_data),
		.o_label       (o_label),
		.o_label_valid (o_label_valid)
	);

	always #HALF_PERIOD i_sclk = ~i_sclk;

	// labels picked up on the falling edge
	always @(negedge i_sclk)
	begin
		if (o_label_valid === 1'b1)
			label_q.push_back(o_label);
	end

	//////////////////////////////////////////////////////////////////////
	// reference model

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_weight();
		logic [31:0] r;
		r = next_rand();
		return int'($signed(r[23:16]));
	endfunction

	function automatic logic [N_IN-1:0] rand_features();
		logic [31:0]     r;
		logic [N_IN-1:0] f;
		for (int i = 0; i < N_IN; i++)
		begin
			r = next_rand();
			f[i] = r[28];
		end
		return f;
	endfunction

	function automatic void randomize_params();
		for (int j = 0; j < N_OUT; j++)
		begin
			model_b[j] = rand_weight();
			for (int i = 0; i < N_IN; i++)
				model_w[j][i] = rand_weight();
		end
	endfunction

	function automatic void clear_params();
		for (int j = 0; j < N_OUT; j++)
		begin
			model_b[j] = 0;
			for (int i = 0; i < N_IN; i++)
				model_w[j][i] = 0;
		end
	endfunction

	// bias plus weights of set features with the first maximum winning
	function automatic int model_label(input logic [N_IN-1:0] feat);
		int score;
		int best;
		int best_score;
		best = 0;
		best_score = 0;
		for (int j = 0; j < N_OUT; j++)
		begin
			score = model_b[j];
			for (int i = 0; i < N_IN; i++)
				if (feat[i])
					score += model_w[j][i];
			if (j == 0 || score > best_score)
			begin
				best = j;
				best_score = score;
			end
		end
		return best;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// reporting

	task automatic end_run();
		if (!run_over)
		begin
			run_over = 1'b1;
			errors += lenet_classifier_top_i.lenet_classifier_props_i.fail_count;
			$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
			if (errors == 0)
				$display("Test OK");
			else
				$display("Test FAILED");
			$finish;
		end
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual)
		begin
			errors++;
			$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic test_done(input string name, input int errs_at_start);
		tests++;
		$display("test %-14s finished with %0d errors", name, errors - errs_at_start);
	endtask

	//////////////////////////////////////////////////////////////////////
	// stream driving from the falling edge

	task automatic send_byte(input logic [7:0] b);
		int waited;
		waited = 0;
		i_in_valid = 1'b1;
		i_in_data  = b;
		while (!o_in_ready && waited < WAIT_LIMIT)
		begin
			@(negedge i_sclk);
			waited++;
		end
		if (!o_in_ready)
		begin
			errors++;
			$display("timeout: input stream not ready for %0d cycles", WAIT_LIMIT);
			end_run();
		end
		else
		begin
			@(negedge i_sclk);
			i_in_valid = 1'b0;
		end
	endtask

	task automatic send_header(input logic [1:0] kind, input logic [5:0] spare);
		stream_byte_t sb;
		sb.hdr.kind   = kind;
		sb.hdr.unused = spare;
		send_byte(sb);
	endtask

	task automatic load_weights();
		stream_byte_t sb;
		send_header(KIND_WEIGHTS, 6'd0);
		for (int j = 0; j < N_OUT; j++)
			for (int i = 0; i < N_IN; i++)
			begin
				sb.weight = 8'(model_w[j][i]);
				send_byte(sb);
			end
	endtask

	task automatic load_biases();
		stream_byte_t sb;
		send_header(KIND_BIASES, 6'd0);
		for (int j = 0; j < N_OUT; j++)
		begin
			sb.weight = 8'(model_b[j]);
			send_byte(sb);
		end
	endtask

	task automatic send_frame(input logic [N_IN-1:0] feat);
		logic [7:0] pkt;
		send_header(KIND_FEATURES, 6'd0);
		for (int b = 0; b < FEAT_BYTES; b++)
		begin
			// padding bits past the last feature are set and must be ignored
			pkt = 8'hff;
			for (int k = 0; k < 8; k++)
				if (b * 8 + k < N_IN)
					pkt[k] = feat[b * 8 + k];
			send_byte(pkt);
		end
	endtask

	task automatic wait_label(output logic [LABEL_W-1:0] lbl);
		int waited;
		waited = 0;
		lbl = '0;
		while (label_q.size() == 0 && waited < WAIT_LIMIT)
		begin
			@(negedge i_sclk);
			waited++;
		end
		if (label_q.size() == 0)
		begin
			errors++;
			$display("timeout: no label within %0d cycles", WAIT_LIMIT);
			end_run();
		end
		else
			lbl = label_q.pop_front();
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests

	task automatic one_hot_test();
		int                 errs;
		logic [N_IN-1:0]    feat;
		logic [LABEL_W-1:0] lbl;
		errs = errors;
		clear_params();
		for (int j = 0; j < N_OUT; j++)
			model_w[j][3 * j] = 1;
		load_weights();
		load_biases();
		for (int j = 0; j < N_OUT; j++)
		begin
			feat = '0;
			feat[3 * j] = 1'b1;
			send_frame(feat);
			wait_label(lbl);
			check_value("one_hot", j, int'(lbl));
		end
		test_done("one_hot", errs);
	endtask

	task automatic random_test();
		int                 errs;
		logic [N_IN-1:0]    feat;
		logic [LABEL_W-1:0] lbl;
		errs = errors;
		randomize_params();
		load_weights();
		load_biases();
		repeat (5)
		begin
			feat = rand_features();
			send_frame(feat);
			wait_label(lbl);
			check_value("random", model_label(feat), int'(lbl));
		end
		test_done("random", errs);
	endtask

	task automatic tie_test();
		int                 errs;
		logic [N_IN-1:0]    feat;
		logic [LABEL_W-1:0] lbl;
		errs = errors;
		clear_params();
		for (int j = 0; j < N_OUT; j++)
			model_b[j] = -3;
		model_w[2][0] = 10;
		model_w[7][0] = 10;
		model_b[2] = 5;
		model_b[7] = 5;
		load_weights();
		load_biases();
		feat = '0;
		feat[0]  = 1'b1;
		feat[50] = 1'b1;
		send_frame(feat);
		wait_label(lbl);
		check_value("ties", 2, int'(lbl));
		test_done("ties", errs);
	endtask

	task automatic zero_features_test();
		int                 errs;
		int                 best;
		logic [LABEL_W-1:0] lbl;
		errs = errors;
		best = 0;
		for (int j = 0; j < N_OUT; j++)
			model_b[j] = rand_weight();
		for (int j = 1; j < N_OUT; j++)
			if (model_b[j] > model_b[best])
				best = j;
		load_biases();
		send_frame('0);
		wait_label(lbl);
		check_value("zero_features", best, int'(lbl));
		test_done("zero_features", errs);
	endtask

	task automatic back_pressure_test();
		int                 errs;
		logic [N_IN-1:0]    feat_a;
		logic [N_IN-1:0]    feat_b;
		logic [LABEL_W-1:0] lbl_a;
		logic [LABEL_W-1:0] lbl_b;
		errs = errors;
		randomize_params();
		load_weights();
		load_biases();
		feat_a = rand_features();
		feat_b = rand_features();
		send_header(KIND_RESERVED, 6'h15);
		// second frame stalls behind the first classification
		send_frame(feat_a);
		send_frame(feat_b);
		wait_label(lbl_a);
		wait_label(lbl_b);
		check_value("back_pressure", model_label(feat_a), int'(lbl_a));
		check_value("back_pressure", model_label(feat_b), int'(lbl_b));
		repeat (40) @(negedge i_sclk);
		check_value("back_pressure", 0, label_q.size());
		test_done("back_pressure", errs);
	endtask

	task automatic reload_test();
		int                 errs;
		int                 first;
		int                 winner;
		logic [31:0]        r;
		logic [N_IN-1:0]    feat;
		logic [LABEL_W-1:0] lbl;
		errs = errors;
		r = next_rand();
		feat = '0;
		feat[int'(r % 32'(N_IN))] = 1'b1;
		first = model_label(feat);
		send_frame(feat);
		wait_label(lbl);
		check_value("reload", first, int'(lbl));
		// new biases outweigh any single weight and move the winner
		winner = (first + 1) % N_OUT;
		for (int j = 0; j < N_OUT; j++)
			model_b[j] = (j == winner) ? 127 : -128;
		load_biases();
		send_frame(feat);
		wait_label(lbl);
		check_value("reload", model_label(feat), int'(lbl));
		test_done("reload", errs);
	endtask

	initial
	begin
		i_sclk     = 1'b0;
		i_rstn     = 1'b0;
		i_in_valid = 1'b0;
		i_in_data  = '0;
		lcg_state  = 32'h15f8;
		tests      = 0;
		checks     = 0;
		errors     = 0;
		run_over   = 1'b0;
		repeat (4) @(negedge i_sclk);
		i_rstn = 1'b1;
		check_value("reset", 1, int'(o_in_ready));
		one_hot_test();
		random_test();
		tie_test();
		zero_features_test();
		back_pressure_test();
		reload_test();
		end_run();
	end

endmodule

//--- lenet_classifier_props.sv
`timescale 1ns/1ns

module lenet_classifier_props
	import lenet_pkg::*;
(
	input logic               i_sclk,
	input logic               i_rstn,
	input logic               i_label_valid,
	input logic [LABEL_W-1:0] i_label,
	input logic               i_rd_gnt,
	input logic               i_wr_gnt,
	input logic               i_in_ready,
	input logic               i_busy
);

	int fail_count = 0;

	// label valid is a single-cycle pulse
	label_pulse: assert property (@(posedge i_sclk) disable iff (!i_rstn)
		i_label_valid |=> !i_label_valid)
		else
		begin
			fail_count++;
			$error("o_label_valid high on two consecutive cycles");
		end

	label_range: assert property (@(posedge i_sclk) disable iff (!i_rstn)
		i_label_valid |-> (i_label < LABEL_W'(N_OUT)))
		else
		begin
			fail_count++;
			$error("o_label out of range while valid");
		end

	one_grant: assert property (@(posedge i_sclk) disable iff (!i_rstn)
		!(i_rd_gnt && i_wr_gnt))
		else
		begin
			fail_count++;
			$error("read and write grants high together");
		end

	// loader holds off while the engine runs
	stall_busy: assert property (@(posedge i_sclk) disable iff (!i_rstn)
		i_busy |-> !i_in_ready)
		else
		begin
			fail_count++;
			$error("o_in_ready high while the engine is busy");
		end

endmodule

bind lenet_classifier_top lenet_classifier_props lenet_classifier_props_i (
	.i_sclk        (i_sclk),
	.i_rstn        (i_rstn),
	.i_label_valid (o_label_valid),
	.i_label       (o_label),
	.i_rd_gnt      (rd_gnt),
	.i_wr_gnt      (wr_gnt),
	.i_in_ready    (o_in_ready),
	.i_busy        (busy)
);

//--- lenet_classifier_top.sv
`timescale 1ns/1ns

module lenet_classifier_top
	import lenet_pkg::*;
(
	input  logic               i_sclk,
	input  logic               i_rstn,

	input  logic               i_in_valid,
	output logic               o_in_ready,
	input  logic [7:0]         i_in_data,

	output logic [LABEL_W-1:0] o_label,
	output logic               o_label_valid
);

	logic                      wr_req;
	logic [ADDR_W-1:0]         wr_addr;
	logic signed [WW-1:0]      wr_data;
	logic                      wr_gnt;
	logic                      rd_req;
	logic [ADDR_W-1:0]         rd_addr;
	logic                      rd_gnt;
	logic                      rd_valid;
	logic signed [WW-1:0]      rd_data;
	logic                      start;
	logic [N_IN-1:0]           features;
	logic                      busy;
	logic                      score_valid;
	logic signed [SCORE_W-1:0] score;
	logic [LABEL_W-1:0]        score_class;

	param_stream_loader param_stream_loader_i (
		.i_sclk     (i_sclk),
		.i_rstn     (i_rstn),
		.i_in_valid (i_in_valid),
		.o_in_ready (o_in_ready),
		.i_in_data  (i_in_data),
		.o_wr_req   (wr_req),
		.o_wr_addr  (wr_addr),
		.o_wr_data  (wr_data),
		.i_wr_gnt   (wr_gnt),
		.o_start    (start),
		.o_features (features),
		.i_busy     (busy)
	);

	param_arbiter param_arbiter_i (
		.i_sclk     (i_sclk),
		.i_rstn     (i_rstn),
		.i_rd_req   (rd_req),
		.i_rd_addr  (rd_addr),
		.o_rd_gnt   (rd_gnt),
		.o_rd_valid (rd_valid),
		.o_rd_data  (rd_data),
		.i_wr_req   (wr_req),
		.i_wr_addr  (wr_addr),
		.i_wr_data  (wr_data),
		.o_wr_gnt   (wr_gnt)
	);

	fc_layer_engine fc_layer_engine_i (
		.i_sclk        (i_sclk),
		.i_rstn        (i_rstn),
		.i_start       (start),
		.i_features    (features),
		.o_busy        (busy),
		.o_rd_req      (rd_req),
		.o_rd_addr     (rd_addr),
		.i_rd_gnt      (rd_gnt),
		.i_rd_valid    (rd_valid),
		.i_rd_data     (rd_data),
		.o_score_valid (score_valid),
		.o_score       (score),
		.o_class       (score_class)
	);

	max_label_picker max_label_picker_i (
		.i_sclk        (i_sclk),
		.i_rstn        (i_rstn),
		.i_score_valid (score_valid),
		.i_score       (score),
		.i_class       (score_class),
		.o_label       (o_label),
		.o_label_valid (o_label_valid)
	);

endmodule

//--- max_label_picker.sv
`timescale 1ns/1ns

module max_label_picker
	import lenet_pkg::*;
(
	input  logic                      i_sclk,
	input  logic                      i_rstn,

	input  logic                      i_score_valid,
	input  logic signed [SCORE_W-1:0] i_score,
	input  logic [LABEL_W-1:0]        i_class,

	output logic [LABEL_W-1:0]        o_label,
	output logic                      o_label_valid
);

	logic signed [SCORE_W-1:0] max_score;
	logic [LABEL_W-1:0]        max_cls;
	logic                      take;

	// strictly greater, so a tie keeps the lower class
	assign take = (i_class == '0) || (i_score > max_score);

	always_ff @(posedge i_sclk)
	begin
		if (i_score_valid && take)
		begin
			max_score <= i_score;
			max_cls   <= i_class;
		end
		if (i_score_valid && i_class == LABEL_W'(N_OUT - 1))
			o_label <= take ? i_class : max_cls;
	end

	always_ff @(posedge i_sclk)
	begin
		if (!i_rstn)
			o_label_valid <= 1'b0;
		else
			o_label_valid <= i_score_valid && (i_class == LABEL_W'(N_OUT - 1));
	end

endmodule

//--- fc_layer_engine.sv
`timescale 1ns/1ns

module fc_layer_engine
	import lenet_pkg::*;
(
	input  logic                      i_sclk,
	input  logic                      i_rstn,

	input  logic                      i_start,
	input  logic [N_IN-1:0]           i_features,
	output logic                      o_busy,

	output logic                      o_rd_req,
	output logic [ADDR_W-1:0]         o_rd_addr,
	input  logic                      i_rd_gnt,
	input  logic                      i_rd_valid,
	input  logic signed [WW-1:0]      i_rd_data,

	output logic                      o_score_valid,
	output logic signed [SCORE_W-1:0] o_score,
	output logic [LABEL_W-1:0]        o_class
);

	logic [N_IN-1:0]           feat_q;
	logic [N_IN-1:0]           mask;
	logic [$clog2(N_IN)-1:0]   low_idx;
	logic                      bias_pend;
	logic [LABEL_W-1:0]        cls;
	logic [1:0]                outstanding;
	logic signed [SCORE_W-1:0] acc;
	logic                      cls_done;

	// lowest feature still to be read for this class
	always_comb
	begin
		low_idx = '0;
		for (int i = N_IN - 1; i >= 0; i--)
			if (mask[i])
				low_idx = i[$clog2(N_IN)-1:0];
	end

	assign o_rd_req  = o_busy && (bias_pend || (|mask));
	assign o_rd_addr = bias_pend ? ADDR_W'(BIAS_BASE) + ADDR_W'(cls)
	                             : ADDR_W'(cls) * ADDR_W'(N_IN) + ADDR_W'(low_idx);

	// all reads issued and returned
	assign cls_done = o_busy && !bias_pend && !(|mask) && (outstanding == 2'd0);

	//////////////////////////////////////////////////////////////////////
	// class sequencing

	always_ff @(posedge i_sclk)
	begin
		if (!i_rstn)
		begin
			o_busy        <= 1'b0;
			bias_pend     <= 1'b0;
			cls           <= '0;
			outstanding   <= '0;
			o_score_valid <= 1'b0;
		end
		else
		begin
			o_score_valid <= cls_done;
			outstanding   <= outstanding + 2'(i_rd_gnt) - 2'(i_rd_valid);
			if (i_start && !o_busy)
			begin
				o_busy    <= 1'b1;
				bias_pend <= 1'b1;
				cls       <= '0;
			end
			else if (cls_done)
			begin
				cls       <= cls + 1'b1;
				bias_pend <= (cls != LABEL_W'(N_OUT - 1));
				o_busy    <= (cls != LABEL_W'(N_OUT - 1));
			end
			else if (i_rd_gnt && bias_pend)
				bias_pend <= 1'b0;
		end
	end

	always_ff @(posedge i_sclk)
	begin
		if (i_start && !o_busy)
		begin
			feat_q <= i_features;
			mask   <= i_features;
			acc    <= '0;
		end
		else if (cls_done)
		begin
			mask    <= feat_q;
			acc     <= '0;
			o_score <= acc;
			o_class <= cls;
		end
		else
		begin
			if (i_rd_gnt && !bias_pend)
				mask[low_idx] <= 1'b0;
			if (i_rd_valid)
				acc <= acc + {{(SCORE_W - WW){i_rd_data[WW-1]}}, i_rd_data};
		end
	end

endmodule

//--- param_stream_loader.sv
`timescale 1ns/1ns

module param_stream_loader
	import lenet_pkg::*;
(
	input  logic                     i_sclk,
	input  logic                     i_rstn,

	input  logic                     i_in_valid,
	output logic                     o_in_ready,
	input  logic [7:0]               i_in_data,

	output logic                     o_wr_req,
	output logic [ADDR_W-1:0]        o_wr_addr,
	output logic signed [WW-1:0]     o_wr_data,
	input  logic                     i_wr_gnt,

	output logic                     o_start,
	output logic [N_IN-1:0]          o_features,
	input  logic                     i_busy
);

	stream_byte_t      in_byte;
	logic              accept;
	logic              rec_open;
	logic [1:0]        rec_kind;
	logic [ADDR_W-1:0] cnt;
	logic              last_byte;

	assign in_byte    = i_in_data;
	assign o_in_ready = !o_wr_req && !i_busy && !o_start;
	assign accept     = i_in_valid && o_in_ready;

	always_comb
	begin
		case (rec_kind)
			KIND_WEIGHTS:  last_byte = (cnt == ADDR_W'(W_BYTES - 1));
			KIND_BIASES:   last_byte = (cnt == ADDR_W'(N_OUT - 1));
			default:       last_byte = (cnt == ADDR_W'(FEAT_BYTES - 1));
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// record FSM and write requests

	always_ff @(posedge i_sclk)
	begin
		if (!i_rstn)
		begin
			rec_open <= 1'b0;
			rec_kind <= KIND_WEIGHTS;
			cnt      <= '0;
			o_wr_req <= 1'b0;
			o_start  <= 1'b0;
		end
		else
		begin
			o_start <= 1'b0;
			if (i_wr_gnt)
				o_wr_req <= 1'b0;
			if (accept && !rec_open)
			begin
				// reserved kind leaves no record open
				rec_kind <= in_byte.hdr.kind;
				rec_open <= (in_byte.hdr.kind != KIND_RESERVED);
				cnt      <= '0;
			end
			else if (accept)
			begin
				cnt <= cnt + 1'b1;
				if (last_byte)
					rec_open <= 1'b0;
				if (rec_kind == KIND_FEATURES)
					o_start <= last_byte;
				else
					o_wr_req <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_sclk)
	begin
		if (accept && rec_open)
		begin
			o_wr_data <= in_byte.weight;
			if (rec_kind == KIND_BIASES)
				o_wr_addr <= ADDR_W'(BIAS_BASE) + cnt;
			else
				o_wr_addr <= cnt;
			// bit k of byte b is feature 8b+k
			if (rec_kind == KIND_FEATURES)
				for (int i = 0; i < N_IN; i++)
					if (int'(cnt) == i / 8)
						o_features[i] <= i_in_data[i % 8];
		end
	end

endmodule

//--- param_arbiter.sv
`timescale 1ns/1ns

module param_arbiter
	import lenet_pkg::*;
(
	input  logic                     i_sclk,
	input  logic                     i_rstn,

	// engine reads
	input  logic                     i_rd_req,
	input  logic [ADDR_W-1:0]        i_rd_addr,
	output logic                     o_rd_gnt,
	output logic                     o_rd_valid,
	output logic signed [WW-1:0]     o_rd_data,

	// loader writes
	input  logic                     i_wr_req,
	input  logic [ADDR_W-1:0]        i_wr_addr,
	input  logic signed [WW-1:0]     i_wr_data,
	output logic                     o_wr_gnt
);

	logic              ram_en;
	logic [ADDR_W-1:0] ram_addr;
	logic              rd_valid_q;

	// engine first, loader takes the port otherwise
	assign o_rd_gnt = i_rd_req;
	assign o_wr_gnt = i_wr_req && !i_rd_req;

	assign ram_en   = o_rd_gnt || o_wr_gnt;
	assign ram_addr = i_rd_req ? i_rd_addr : i_wr_addr;

	always_ff @(posedge i_sclk)
	begin
		if (!i_rstn)
			rd_valid_q <= 1'b0;
		else
			rd_valid_q <= o_rd_gnt;
	end

	assign o_rd_valid = rd_valid_q;

	weight_ram weight_ram_i (
		.i_sclk  (i_sclk),
		.i_en    (ram_en),
		.i_we    (o_wr_gnt),
		.i_addr  (ram_addr),
		.i_wdata (i_wr_data),
		.o_rdata (o_rd_data)
	);

endmodule

//--- weight_ram.sv
`timescale 1ns/1ns

module weight_ram
	import lenet_pkg::*;
(
	input  logic                     i_sclk,
	input  logic                     i_en,
	input  logic                     i_we,
	input  logic [ADDR_W-1:0]        i_addr,
	input  logic signed [WW-1:0]     i_wdata,
	output logic signed [WW-1:0]     o_rdata
);

	logic signed [WW-1:0] mem [RAM_DEPTH];

	// read data registered, one cycle after enable
	always_ff @(posedge i_sclk)
	begin
		if (i_en)
		begin
			if (i_we)
			begin
				mem[i_addr] <= i_wdata;
			end
			else
			begin
				o_rdata <= mem[i_addr];
			end
		end
	end

endmodule

//--- lenet_pkg.sv
package lenet_pkg;

	//////////////////////////////////////////////////////////////////////
	// layer geometry

	localparam int N_IN       = 84;
	localparam int N_OUT      = 10;
	localparam int FEAT_BYTES = (N_IN + 7) / 8;
	localparam int W_BYTES    = N_OUT * N_IN;

	// biases sit right after the weight block
	localparam int BIAS_BASE  = W_BYTES;
	localparam int RAM_DEPTH  = W_BYTES + N_OUT;
	localparam int ADDR_W     = $clog2(RAM_DEPTH);

	localparam int WW         = 8;
	localparam int SCORE_W    = 16;
	localparam int LABEL_W    = 4;

	//////////////////////////////////////////////////////////////////////
	// record header kinds

	localparam logic [1:0] KIND_WEIGHTS  = 2'd0;
	localparam logic [1:0] KIND_BIASES   = 2'd1;
	localparam logic [1:0] KIND_FEATURES = 2'd2;
	localparam logic [1:0] KIND_RESERVED = 2'd3;

	// one stream byte, read as a header or as a weight
	typedef union packed {
		struct packed {
			logic [1:0] kind;
			logic [5:0] unused;
		} hdr;
		logic signed [7:0] weight;
	} stream_byte_t;

endpackage
